// ==== core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// **********************************************************************
// core widths and reset values
// **********************************************************************

// data path and address width, rv64
`define XLEN 64

// instruction word width
`define ILEN 32

// register file sizing
`define REG_ADDR_W 5
`define REG_COUNT  32

// first fetch address after reset
`define RESET_PC 64'h0000_0000_8000_0000

`endif

// ==== core_pkg.sv ====
`default_nettype none
`include "core_config.svh"

package core_pkg;

    // **********************************************************************
    // basic vector types
    // **********************************************************************
    typedef logic [`XLEN-1:0]       xlen_t;      // data or address word
    typedef logic [`ILEN-1:0]       inst_t;      // raw instruction
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;  // register index

    // alu operation select, pass forwards op2 for lui
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_JAL
    } branch_e;

    // four-phase fetch handshake states
    typedef enum logic [1:0] {
        REQUEST,
        RELEASE,
        EXECUTE
    } fetch_state_e;

    // **********************************************************************
    // stage records
    // **********************************************************************
    typedef struct packed {
        xlen_t pc;
        inst_t inst;
    } fetch_pkt_t;

    typedef struct packed {
        xlen_t     pc;
        xlen_t     op1;
        xlen_t     op2;
        alu_op_e   alu_op;
        branch_e   br_kind;
        xlen_t     br_target;   // pc + imm, for branches and jal
        logic      rd_we;
        reg_addr_t rd_addr;
    } decode_pkt_t;

    typedef struct packed {
        logic      rd_we;
        reg_addr_t rd_addr;
        xlen_t     rd_data;
        xlen_t     next_pc;
    } exec_pkt_t;

endpackage

`default_nettype wire

// ==== fetch_unit.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "core_config.svh"

module fetch_unit import core_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    // instruction memory, four-phase req/ack
    output logic       imem_req_o,
    output xlen_t      imem_addr_o,
    input  logic       imem_ack_i,
    input  inst_t      imem_data_i,
    // from execute
    input  xlen_t      next_pc_i,
    // to decode
    output fetch_pkt_t fetch_o,
    output logic       exec_o
);

    fetch_state_e state_q;
    fetch_state_e state_d;
    xlen_t        pc_q;
    inst_t        inst_q;
    logic         ack_seen;

    // first edge with ack high while requesting
    assign ack_seen = (state_q == REQUEST) && imem_req_o && imem_ack_i;

    // **********************************************************************
    // handshake state machine
    // **********************************************************************
    always_comb begin
        state_d = state_q;
        case (state_q)
            REQUEST: begin
                if (ack_seen) begin
                    state_d = RELEASE;
                end
            end
            RELEASE: begin
                if (!imem_ack_i) begin      // memory has let go of ack
                    state_d = EXECUTE;
                end
            end
            EXECUTE: state_d = REQUEST;   // single cycle
            default: state_d = REQUEST;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            state_q    <= REQUEST;
            imem_req_o <= 1'b0;
            pc_q       <= `RESET_PC;
        end else begin
            state_q    <= state_d;
            // req follows the next state, so it drops on the ack edge
            imem_req_o <= (state_d == REQUEST);
            if (state_q == EXECUTE) begin
                pc_q <= next_pc_i;
            end
        end
    end

    // instruction latch
    always_ff @(posedge clk) begin
        if (ack_seen) begin
            inst_q <= imem_data_i;
        end
    end

    assign imem_addr_o  = pc_q;   // only moves at the end of EXECUTE
    assign fetch_o.pc   = pc_q;
    assign fetch_o.inst = inst_q;
    assign exec_o       = (state_q == EXECUTE);

endmodule

`default_nettype wire

// ==== decode_unit.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "core_config.svh"

module decode_unit import core_pkg::*; (
    input  fetch_pkt_t  fetch_i,
    // register file read ports
    output reg_addr_t   rs1_addr_o,
    output reg_addr_t   rs2_addr_o,
    input  xlen_t       rs1_data_i,
    input  xlen_t       rs2_data_i,
    output decode_pkt_t decode_o
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i;
    xlen_t      imm_b;
    xlen_t      imm_u;
    xlen_t      imm_j;
    xlen_t      br_imm;
    logic       rd_we;
    alu_op_e    alu_op;
    branch_e    br_kind;
    xlen_t      op1;
    xlen_t      op2;

    // **********************************************************************
    // fields and immediates
    // **********************************************************************
    assign opcode     = fetch_i.inst[6:0];
    assign funct3     = fetch_i.inst[14:12];
    assign funct7     = fetch_i.inst[31:25];
    assign rs1_addr_o = fetch_i.inst[19:15];
    assign rs2_addr_o = fetch_i.inst[24:20];

    assign imm_i = {{(`XLEN-12){fetch_i.inst[31]}}, fetch_i.inst[31:20]};
    assign imm_b = {{(`XLEN-13){fetch_i.inst[31]}}, fetch_i.inst[31], fetch_i.inst[7],
                    fetch_i.inst[30:25], fetch_i.inst[11:8], 1'b0};
    assign imm_u = {{(`XLEN-32){fetch_i.inst[31]}}, fetch_i.inst[31:12], 12'b0};
    assign imm_j = {{(`XLEN-21){fetch_i.inst[31]}}, fetch_i.inst[31], fetch_i.inst[19:12],
                    fetch_i.inst[20], fetch_i.inst[30:21], 1'b0};

    // **********************************************************************
    // control and operand select
    // **********************************************************************
    always_comb begin
        rd_we   = 1'b0;   // anything not matched retires as a nop
        alu_op  = ALU_ADD;
        br_kind = BR_NONE;
        op1     = rs1_data_i;
        op2     = rs2_data_i;
        br_imm  = imm_b;
        case (opcode)
            OPC_OP: begin
                rd_we = (funct7 == 7'b0000000);
                case (funct3)
                    3'b000: begin
                        alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                        rd_we  = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                    end
                    3'b001:  alu_op = ALU_SLL;
                    3'b010:  alu_op = ALU_SLT;
                    3'b100:  alu_op = ALU_XOR;
                    3'b101:  alu_op = ALU_SRL;   // sra has funct7 set, dropped above
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: rd_we  = 1'b0;      // sltu
                endcase
            end
            OPC_OP_IMM: begin
                op2   = imm_i;
                rd_we = 1'b1;
                case (funct3)
                    3'b000:  alu_op = ALU_ADD;
                    3'b010:  alu_op = ALU_SLT;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    3'b001: begin
                        alu_op = ALU_SLL;
                        rd_we  = (fetch_i.inst[31:26] == 6'b0);
                    end
                    3'b101: begin
                        alu_op = ALU_SRL;
                        rd_we  = (fetch_i.inst[31:26] == 6'b0);  // no srai
                    end
                    default: rd_we = 1'b0;   // sltiu
                endcase
            end
            OPC_LUI: begin
                op1    = '0;
                op2    = imm_u;
                alu_op = ALU_PASS;
                rd_we  = 1'b1;
            end
            OPC_BRANCH: begin
                if (funct3 == 3'b000) begin
                    br_kind = BR_BEQ;
                end else if (funct3 == 3'b001) begin
                    br_kind = BR_BNE;
                end
            end
            OPC_JAL: begin
                op1     = fetch_i.pc;   // link value pc + 4 through the alu
                op2     = xlen_t'(4);
                br_imm  = imm_j;
                br_kind = BR_JAL;
                rd_we   = 1'b1;
            end
            default: ;
        endcase
    end

    assign decode_o.pc        = fetch_i.pc;
    assign decode_o.op1       = op1;
    assign decode_o.op2       = op2;
    assign decode_o.alu_op    = alu_op;
    assign decode_o.br_kind   = br_kind;
    assign decode_o.br_target = fetch_i.pc + br_imm;
    assign decode_o.rd_we     = rd_we;
    assign decode_o.rd_addr   = fetch_i.inst[11:7];

endmodule

`default_nettype wire

// ==== execute_unit.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "core_config.svh"

module execute_unit import core_pkg::*; (
    input  decode_pkt_t decode_i,
    output exec_pkt_t   exec_o
);

    logic [$clog2(`XLEN)-1:0] shamt;
    xlen_t                    result;
    xlen_t                    pc_plus4;
    logic                     taken;

    assign shamt    = decode_i.op2[$clog2(`XLEN)-1:0];   // rv64 shifts by 0..63
    assign pc_plus4 = decode_i.pc + xlen_t'(4);

    // **********************************************************************
    // alu
    // **********************************************************************
    always_comb begin
        case (decode_i.alu_op)
            ALU_ADD:  result = decode_i.op1 + decode_i.op2;
            ALU_SUB:  result = decode_i.op1 - decode_i.op2;
            ALU_AND:  result = decode_i.op1 & decode_i.op2;
            ALU_OR:   result = decode_i.op1 | decode_i.op2;
            ALU_XOR:  result = decode_i.op1 ^ decode_i.op2;
            ALU_SLT:  result = {{(`XLEN-1){1'b0}},
                                $signed(decode_i.op1) < $signed(decode_i.op2)};
            ALU_SLL:  result = decode_i.op1 << shamt;
            ALU_SRL:  result = decode_i.op1 >> shamt;
            ALU_PASS: result = decode_i.op2;
            default:  result = '0;
        endcase
    end

    // branch decision
    always_comb begin
        case (decode_i.br_kind)
            BR_BEQ:  taken = (decode_i.op1 == decode_i.op2);
            BR_BNE:  taken = (decode_i.op1 != decode_i.op2);
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign exec_o.rd_we   = decode_i.rd_we;
    assign exec_o.rd_addr = decode_i.rd_addr;
    assign exec_o.rd_data = result;
    assign exec_o.next_pc = taken ? decode_i.br_target : pc_plus4;

endmodule

`default_nettype wire

// ==== result_unit.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "core_config.svh"

module result_unit import core_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       exec_i,
    input  exec_pkt_t  exec_pkt_i,
    input  fetch_pkt_t fetch_i,
    // read ports for decode
    input  reg_addr_t  rs1_addr_i,
    input  reg_addr_t  rs2_addr_i,
    output xlen_t      rs1_data_o,
    output xlen_t      rs2_data_o,
    // retired instruction report
    output logic       commit_valid_o,
    output xlen_t      commit_pc_o,
    output inst_t      commit_inst_o,
    output logic       commit_we_o,
    output reg_addr_t  commit_rd_o,
    output xlen_t      commit_data_o
);

    xlen_t regs_q [`REG_COUNT];
    logic  wr_en;

    assign wr_en = exec_i && exec_pkt_i.rd_we && (exec_pkt_i.rd_addr != '0);   // x0 dropped

    // **********************************************************************
    // register file
    // **********************************************************************
    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[exec_pkt_i.rd_addr] <= exec_pkt_i.rd_data;
        end
    end

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

    // commit record, one cycle after the write edge
    always_ff @(posedge clk) begin
        if (rst_n) begin
            commit_valid_o <= 1'b0;
        end else begin
            commit_valid_o <= exec_i;
        end
    end

    always_ff @(posedge clk) begin
        if (exec_i) begin
            commit_pc_o   <= fetch_i.pc;
            commit_inst_o <= fetch_i.inst;
            commit_we_o   <= exec_pkt_i.rd_we;   // reports we even for x0
            commit_rd_o   <= exec_pkt_i.rd_addr;
            commit_data_o <= exec_pkt_i.rd_data;
        end
    end

endmodule

`default_nettype wire

// ==== rv_core.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "core_config.svh"

module rv_core import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    // instruction memory
    output logic      imem_req_o,
    output xlen_t     imem_addr_o,
    input  logic      imem_ack_i,
    input  inst_t     imem_data_i,
    // retire report
    output logic      commit_valid_o,
    output xlen_t     commit_pc_o,
    output inst_t     commit_inst_o,
    output logic      commit_we_o,
    output reg_addr_t commit_rd_o,
    output xlen_t     commit_data_o
);

    fetch_pkt_t  fetch_pkt;
    logic        exec_strobe;   // high for the single EXECUTE cycle
    reg_addr_t   rs1_addr;
    reg_addr_t   rs2_addr;
    xlen_t       rs1_data;
    xlen_t       rs2_data;
    decode_pkt_t decode_pkt;
    exec_pkt_t   exec_pkt;

    // **********************************************************************
    // fetch -> decode -> execute -> result
    // **********************************************************************
    fetch_unit u_fetch (
        .clk         (clk                ),
        .rst_n       (rst_n              ),
        .imem_req_o  (imem_req_o         ),
        .imem_addr_o (imem_addr_o        ),
        .imem_ack_i  (imem_ack_i         ),
        .imem_data_i (imem_data_i        ),
        .next_pc_i   (exec_pkt.next_pc   ),
        .fetch_o     (fetch_pkt          ),
        .exec_o      (exec_strobe        )
    );

    decode_unit u_decode (
        .fetch_i    (fetch_pkt ),
        .rs1_addr_o (rs1_addr  ),
        .rs2_addr_o (rs2_addr  ),
        .rs1_data_i (rs1_data  ),
        .rs2_data_i (rs2_data  ),
        .decode_o   (decode_pkt)
    );

    execute_unit u_execute (
        .decode_i (decode_pkt),
        .exec_o   (exec_pkt  )
    );

    result_unit u_result (
        .clk            (clk           ),
        .rst_n          (rst_n         ),
        .exec_i         (exec_strobe   ),
        .exec_pkt_i     (exec_pkt      ),
        .fetch_i        (fetch_pkt     ),
        .rs1_addr_i     (rs1_addr      ),
        .rs2_addr_i     (rs2_addr      ),
        .rs1_data_o     (rs1_data      ),
        .rs2_data_o     (rs2_data      ),
        .commit_valid_o (commit_valid_o),
        .commit_pc_o    (commit_pc_o   ),
        .commit_inst_o  (commit_inst_o ),
        .commit_we_o    (commit_we_o   ),
        .commit_rd_o    (commit_rd_o   ),
        .commit_data_o  (commit_data_o )
    );

endmodule

`default_nettype wire

// ==== tb_rv_core.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "core_config.svh"

module tb_rv_core import core_pkg::*; ();

    localparam int    PROG_LEN   = 60;
    localparam int    PERIOD     = 20;
    localparam int    TIMEOUT_NS = PROG_LEN * 20 * PERIOD;
    localparam inst_t NOP        = 32'h0000_0013;            // addi x0, x0, 0
    localparam xlen_t PROG_END   = `RESET_PC + 4 * PROG_LEN;
    // supported funct3 codes at three bits per entry
    localparam logic [20:0] R_F3 = {3'd0, 3'd1, 3'd2, 3'd4, 3'd5, 3'd6, 3'd7};
    localparam logic [14:0] I_F3 = {3'd0, 3'd2, 3'd4, 3'd6, 3'd7};

    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        xlen_t     data;
        xlen_t     next_pc;
    } expect_t;

    logic      clk;
    logic      rst_n;
    logic      imem_req_o;
    xlen_t     imem_addr_o;
    logic      imem_ack_i;
    inst_t     imem_data_i;
    logic      commit_valid_o;
    xlen_t     commit_pc_o;
    inst_t     commit_inst_o;
    logic      commit_we_o;
    reg_addr_t commit_rd_o;
    xlen_t     commit_data_o;

    inst_t       prog [PROG_LEN];
    xlen_t       model_regs [`REG_COUNT];
    xlen_t       model_pc;
    logic [31:0] lcg_state      = 32'd64780;
    int          error_count    = 0;
    int          check_count    = 0;
    int          commit_count   = 0;
    int          ack_count      = 0;
    logic        run_done       = 1'b0;
    logic        prev_req       = 1'b0;
    xlen_t       prev_addr      = '0;
    logic        first_req_seen = 1'b0;

    rv_core dut (
        .clk            (clk           ),
        .rst_n          (rst_n         ),
        .imem_req_o     (imem_req_o    ),
        .imem_addr_o    (imem_addr_o   ),
        .imem_ack_i     (imem_ack_i    ),
        .imem_data_i    (imem_data_i   ),
        .commit_valid_o (commit_valid_o),
        .commit_pc_o    (commit_pc_o   ),
        .commit_inst_o  (commit_inst_o ),
        .commit_we_o    (commit_we_o   ),
        .commit_rd_o    (commit_rd_o   ),
        .commit_data_o  (commit_data_o )
    );

    always #(PERIOD / 2) clk = ~clk;

    // **********************************************************************
    // helpers
    // **********************************************************************
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 8;   // low bits of an lcg cycle too fast
    endfunction

    function automatic int rand_below(int n);
        return int'(lcg_next() % n);
    endfunction

    function automatic inst_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic inst_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                    reg_addr_t rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic inst_t enc_u(logic [19:0] imm, reg_addr_t rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic inst_t enc_b(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic inst_t enc_j(logic [20:0] imm, reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // memory image with nop outside the program
    function automatic inst_t fetch_word(xlen_t addr);
        xlen_t idx;
        if (addr < `RESET_PC) begin
            return NOP;
        end
        idx = (addr - `RESET_PC) >> 2;
        if (idx >= PROG_LEN) begin
            return NOP;
        end
        return prog[idx];
    endfunction

    task automatic check_value(string what, logic [63:0] got, logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic print_summary();
        $display("summary: %0d commits, %0d fetches, %0d checks, %0d errors",
                 commit_count, ack_count, check_count, error_count);
    endtask

    // directed head then a random tail with forward-only control flow
    task automatic build_program();
        int          pick;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [11:0] imm12;
        logic [19:0] upper;
        logic [2:0]  f3;
        logic [12:0] offs;
        prog[0]  = enc_u(20'h80000, 5'd1);                  // negative upper
        prog[1]  = enc_i(12'hfff, 5'd0, 3'd0, 5'd2);         // x2 = -1
        prog[2]  = enc_i(12'd40, 5'd0, 3'd0, 5'd3);
        prog[3]  = enc_r(7'h00, 5'd3, 5'd2, 3'd1, 5'd4);     // sll by 40
        prog[4]  = enc_r(7'h00, 5'd3, 5'd2, 3'd5, 5'd5);     // srl by 40
        prog[5]  = enc_r(7'h00, 5'd3, 5'd1, 3'd2, 5'd6);     // signed slt
        prog[6]  = enc_r(7'h20, 5'd3, 5'd0, 3'd0, 5'd7);     // sub wraps
        prog[7]  = enc_i(12'd123, 5'd3, 3'd0, 5'd0);         // write to x0
        prog[8]  = enc_r(7'h00, 5'd3, 5'd0, 3'd0, 5'd8);
        prog[9]  = enc_i(12'd33, 5'd3, 3'd1, 5'd9);
        prog[10] = enc_i(12'd36, 5'd1, 3'd5, 5'd10);
        prog[11] = enc_b(13'd8, 5'd8, 5'd3, 3'd0);           // beq taken
        prog[12] = enc_i(12'd99, 5'd0, 3'd0, 5'd11);
        prog[13] = enc_b(13'd8, 5'd8, 5'd3, 3'd1);           // bne not taken
        prog[14] = enc_j(21'd8, 5'd12);
        prog[15] = enc_i(12'd7, 5'd0, 3'd0, 5'd13);
        prog[16] = 32'h0000_0003;                            // unsupported load
        prog[17] = enc_r(7'h20, 5'd3, 5'd1, 3'd5, 5'd14);    // unsupported sra
        prog[18] = enc_i(12'h800, 5'd1, 3'd4, 5'd15);
        prog[19] = enc_i(12'hffb, 5'd1, 3'd2, 5'd14);
        for (int k = 20; k < PROG_LEN; k++) begin
            pick  = rand_below(8);
            rd    = reg_addr_t'(rand_below(16));
            rs1   = reg_addr_t'(rand_below(16));
            rs2   = reg_addr_t'(rand_below(16));
            imm12 = 12'(lcg_next());
            upper = 20'(lcg_next());
            case (pick)
                0, 1: begin
                    f3 = R_F3[3 * rand_below(7) +: 3];
                    if (f3 == 3'd0 && rand_below(2) == 1) begin
                        prog[k] = enc_r(7'h20, rs2, rs1, f3, rd);
                    end else begin
                        prog[k] = enc_r(7'h00, rs2, rs1, f3, rd);
                    end
                end
                2, 3: begin
                    f3 = I_F3[3 * rand_below(5) +: 3];
                    prog[k] = enc_i(imm12, rs1, f3, rd);
                end
                4: prog[k] = enc_i({6'b0, imm12[5:0]}, rs1, (imm12[6] ? 3'd5 : 3'd1), rd);
                5: prog[k] = enc_u(upper, rd);
                6: begin
                    offs = (rand_below(2) == 1) ? 13'd12 : 13'd8;
                    if (rand_below(3) == 0) begin
                        prog[k] = enc_j(21'(offs), rd);
                    end else begin
                        prog[k] = enc_b(offs, rs2, rs1, (upper[0] ? 3'd1 : 3'd0));
                    end
                end
                default: prog[k] = {upper, imm12[4:0], 7'b0000011};
            endcase
        end
    endtask

    // **********************************************************************
    // architectural model, one instruction per call
    // **********************************************************************
    function automatic expect_t ref_step(xlen_t pc, inst_t inst);
        expect_t    r;
        xlen_t      a;
        xlen_t      b;
        xlen_t      imm_i;
        xlen_t      imm_b;
        xlen_t      imm_u;
        xlen_t      imm_j;
        logic [2:0] f3;
        logic [6:0] f7;
        a     = model_regs[inst[19:15]];   // x0 is never written
        b     = model_regs[inst[24:20]];
        f3    = inst[14:12];
        f7    = inst[31:25];
        imm_i = {{52{inst[31]}}, inst[31:20]};
        imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
        imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        r.we      = 1'b0;
        r.rd      = inst[11:7];
        r.data    = '0;
        r.next_pc = pc + 64'd4;
        case (inst[6:0])
            7'b0110011: begin
                if (f7 == 7'h00) begin
                    r.we = 1'b1;
                    case (f3)
                        3'd0:    r.data = a + b;
                        3'd1:    r.data = a << b[5:0];
                        3'd2:    r.data = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                        3'd4:    r.data = a ^ b;
                        3'd5:    r.data = a >> b[5:0];
                        3'd6:    r.data = a | b;
                        3'd7:    r.data = a & b;
                        default: r.we = 1'b0;
                    endcase
                end else if (f7 == 7'h20 && f3 == 3'd0) begin
                    r.we   = 1'b1;
                    r.data = a - b;
                end
            end
            7'b0010011: begin
                r.we = 1'b1;
                case (f3)
                    3'd0:    r.data = a + imm_i;
                    3'd2:    r.data = ($signed(a) < $signed(imm_i)) ? 64'd1 : 64'd0;
                    3'd4:    r.data = a ^ imm_i;
                    3'd6:    r.data = a | imm_i;
                    3'd7:    r.data = a & imm_i;
                    3'd1: begin
                        r.we   = (inst[31:26] == 6'b0);
                        r.data = a << inst[25:20];
                    end
                    3'd5: begin
                        r.we   = (inst[31:26] == 6'b0);   // srai retires as nop
                        r.data = a >> inst[25:20];
                    end
                    default: r.we = 1'b0;
                endcase
            end
            7'b0110111: begin
                r.we   = 1'b1;
                r.data = imm_u;
            end
            7'b1100011: begin
                if ((f3 == 3'd0 && a == b) || (f3 == 3'd1 && a != b)) begin
                    r.next_pc = pc + imm_b;
                end
            end
            7'b1101111: begin
                r.we      = 1'b1;
                r.data    = pc + 64'd4;
                r.next_pc = pc + imm_j;
            end
            default: ;
        endcase
        return r;
    endfunction

    // **********************************************************************
    // stimulus, memory and checking processes
    // **********************************************************************
    initial begin
        clk         = 1'b0;
        rst_n       = 1'b1;   // reset asserted
        imem_ack_i  = 1'b0;
        imem_data_i = '0;
        model_pc    = `RESET_PC;
        for (int i = 0; i < `REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        build_program();
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b0;
        wait (run_done);
        repeat (2) @(posedge clk);
        print_summary();
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // four-phase responder with random ack and release delays
    initial begin : responder
        int delay;
        forever begin
            @(posedge clk);
            #2;
            if (imem_req_o === 1'b1 && imem_ack_i == 1'b0) begin
                delay = rand_below(6);
                repeat (delay) begin
                    @(posedge clk);
                    #2;
                end
                imem_ack_i  = 1'b1;
                imem_data_i = fetch_word(imem_addr_o);
                ack_count++;
                do begin
                    @(posedge clk);
                    #2;
                end while (imem_req_o === 1'b1);
                delay = rand_below(6);
                repeat (delay) begin
                    @(posedge clk);
                    #2;
                end
                imem_ack_i = 1'b0;
            end
        end
    end

    // handshake rules on the fetch port
    always @(posedge clk) begin
        #1;
        if (imem_req_o === 1'b1) begin
            if (!prev_req) begin
                check_value("ack low when req rises", imem_ack_i, 1'b0);
                if (!first_req_seen) begin
                    check_value("first fetch address", imem_addr_o, `RESET_PC);
                    first_req_seen = 1'b1;
                end
            end else begin
                check_value("address held while req high", imem_addr_o, prev_addr);
            end
        end
        prev_req  = (imem_req_o === 1'b1);
        prev_addr = imem_addr_o;
    end

    // commit compare against the model
    always @(posedge clk) begin
        expect_t exp_r;
        #1;
        if (commit_valid_o === 1'b1 && !run_done) begin
            commit_count++;
            exp_r = ref_step(model_pc, fetch_word(model_pc));
            check_value("commit pc", commit_pc_o, model_pc);
            check_value("commit inst", 64'(commit_inst_o), 64'(fetch_word(model_pc)));
            check_value("commit we", commit_we_o, exp_r.we);
            if (exp_r.we) begin
                check_value("commit rd", commit_rd_o, exp_r.rd);
                check_value("commit data", commit_data_o, exp_r.data);
            end
            check_value("fetches per commit", ack_count, commit_count);
            if (exp_r.we && exp_r.rd != '0) begin
                model_regs[exp_r.rd] = exp_r.data;
            end
            model_pc = exp_r.next_pc;
            if (model_pc >= PROG_END) begin
                run_done = 1'b1;   // control flow only moves forward
            end
        end
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the core stopped committing after %0d instructions", commit_count);
        print_summary();
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
core_pkg.sv
fetch_unit.sv
decode_unit.sv
execute_unit.sv
result_unit.sv
rv_core.sv
tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - include_dirs:
      - .
    files:
      - core_pkg.sv
      - fetch_unit.sv
      - decode_unit.sv
      - execute_unit.sv
      - result_unit.sv
      - rv_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_rv_core.sv
